// File: axi_node.f
+incdir+tests
logic/axi_node_pkg.sv
logic/axi_ar_if.sv
logic/axi_r_if.sv
logic/axi_ar_decoder.sv
logic/axi_ar_arbiter.sv
logic/axi_r_router.sv
logic/axi_node.sv
tests/axi_node_tb.sv

// File: tests/axi_node_tb_table.svh
// columns: slave port, address, burst length (beats - 1), id, expected master port
// map: m0 0x0xxx_xxxx, m1 0x1xxx_xxxx and 0x4xxx_xxxx, m2 0x2xxx_xxxx on slave port 0 only

task automatic load_table();
   add_row(0, 32'h0000_0100, 8'd3,  4'h1, 0);
   add_row(1, 32'h1000_0040, 8'd0,  4'h2, 1);
   add_row(0, 32'h1000_0200, 8'd7,  4'h3, 1);            // both ports on master 1
   add_row(1, 32'h1800_0000, 8'd5,  4'h4, 1);
   add_row(0, 32'h2000_0010, 8'd2,  4'h5, 2);
   add_row(1, 32'h2000_0010, 8'd2,  4'h6, exp_decerr);   // m2 not connected here
   add_row(0, 32'h4000_0800, 8'd4,  4'h7, 1);            // region 1
   add_row(1, 32'h4ff0_0000, 8'd1,  4'h8, 1);
   add_row(0, 32'h3000_0000, 8'd3,  4'h9, exp_decerr);   // only disabled rules here
   add_row(1, 32'h0ff0_0000, 8'd15, 4'ha, 0);
   add_row(0, 32'h1000_1000, 8'd2,  4'hb, 1);
   add_row(1, 32'h1000_2000, 8'd2,  4'hc, 1);
   add_row(0, 32'h8000_0000, 8'd0,  4'hd, exp_decerr);   // unmapped
   add_row(1, 32'h0000_0004, 8'd6,  4'he, 0);
endtask

// File: tests/axi_node_tb.sv
`timescale 1ns/10ps

module axi_node_tb;
   import axi_node_pkg::*;

   localparam int max_rows   = 16;
   localparam int exp_decerr = -1;   // row answered by the internal decerr responder

   logic clk;
   logic rst_n_i;
   logic [n_slave_port-1:0]                  slave_arvalid_i, slave_arready_o;
   logic [n_slave_port-1:0][addr_w-1:0]      slave_araddr_i;
   logic [n_slave_port-1:0][len_w-1:0]       slave_arlen_i;
   logic [n_slave_port-1:0][id_in_w-1:0]     slave_arid_i, slave_rid_o;
   logic [n_slave_port-1:0]                  slave_rvalid_o, slave_rready_i, slave_rlast_o;
   logic [n_slave_port-1:0][data_w-1:0]      slave_rdata_o;
   logic [n_slave_port-1:0][resp_w-1:0]      slave_rresp_o;
   logic [n_master_port-1:0]                 master_arvalid_o, master_arready_i;
   logic [n_master_port-1:0][addr_w-1:0]     master_araddr_o;
   logic [n_master_port-1:0][len_w-1:0]      master_arlen_o;
   logic [n_master_port-1:0][id_out_w-1:0]   master_arid_o, master_rid_i;
   logic [n_master_port-1:0]                 master_rvalid_i, master_rready_o, master_rlast_i;
   logic [n_master_port-1:0][data_w-1:0]     master_rdata_i;
   logic [n_master_port-1:0][resp_w-1:0]     master_rresp_i;
   logic [n_region-1:0][n_master_port-1:0][addr_w-1:0] cfg_start_addr_i, cfg_end_addr_i;
   logic [n_region-1:0][n_master_port-1:0]             cfg_valid_rule_i;
   logic [n_slave_port-1:0][n_master_port-1:0]         cfg_connectivity_map_i;

   // --------------------
   // stimulus table
   int                 row_slave [max_rows];
   logic [addr_w-1:0]  row_addr  [max_rows];
   logic [len_w-1:0]   row_len   [max_rows];
   logic [id_in_w-1:0] row_id    [max_rows];
   int                 row_mst   [max_rows];   // expected master port or exp_decerr
   int                 n_rows;

   // the one burst in flight on each slave port
   logic               exp_valid [n_slave_port];
   logic               exp_ar    [n_slave_port];   // master side request seen
   logic [addr_w-1:0]  exp_addr  [n_slave_port];
   logic [len_w-1:0]   exp_len   [n_slave_port];
   logic [id_in_w-1:0] exp_id    [n_slave_port];
   int                 exp_mst   [n_slave_port];
   int                 exp_beat  [n_slave_port];
   int                 cur_row   [n_slave_port];   // row on the slave ar lines

   // memory models hold at most one request per slave port
   logic                mem_pend [n_master_port][n_slave_port];
   logic [addr_w-1:0]   mem_addr [n_master_port][n_slave_port];
   logic [len_w-1:0]    mem_len  [n_master_port][n_slave_port];
   logic [id_out_w-1:0] mem_id   [n_master_port][n_slave_port];
   logic                mem_busy [n_master_port];
   int                  mem_cur  [n_master_port];   // slave port being answered
   int                  mem_beat [n_master_port];

   integer seed = 32'hf81c;
   int     bursts_done;

   axi_node i_dut (.*);

   always #20 clk = ~clk;

   task automatic add_row(input int s, input logic [addr_w-1:0] a, input logic [len_w-1:0] l,
                          input logic [id_in_w-1:0] id, input int m);
      row_slave[n_rows] = s;
      row_addr[n_rows]  = a;
      row_len[n_rows]   = l;
      row_id[n_rows]    = id;
      row_mst[n_rows]   = m;
      n_rows++;
   endtask

   `include "axi_node_tb_table.svh"

   // beat k of a burst with the master index in the top byte
   function automatic logic [data_w-1:0] mem_word(input int m, input logic [addr_w-1:0] a,
                                                  input int k);
      logic [data_w-1:0] w;
      w                 = a + addr_w'(4 * k);
      w[data_w-1 -: 8]  = 8'(m);
      return w;
   endfunction

   // --------------------
   // checks
   task automatic stop_run();
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_run(input string msg);
      $display("error %0t %s", $time, msg);
      stop_run();
   endtask

   task automatic check_id(input string name, input id_out_u got, input id_out_u exp);
      if (got.raw !== exp.raw) begin
         $display("error %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
         stop_run();
      end
   endtask

   task automatic check_data(input string name, input logic [data_w-1:0] got, exp);
      if (got !== exp) begin
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_resp(input string name, input logic [resp_w-1:0] got, exp);
      if (got !== exp) begin
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_addr(input string name, input logic [addr_w-1:0] got, exp);
      if (got !== exp) begin
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_len(input string name, input logic [len_w-1:0] got, exp);
      if (got !== exp) begin
         $display("error %0t %s got %0d expected %0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, exp);
      if (got !== exp) begin
         $display("error %0t %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   // --------------------
   // observers run at the falling edge where all lines are settled
   task automatic watch_slave_ar();
      int r;
      for (int s = 0; s < n_slave_port; s++) begin
         if (slave_arvalid_i[s] && slave_arready_o[s]) begin
            if (exp_valid[s]) begin
               abort_run($sformatf("slave port %0d took a request before its burst ended", s));
            end
            r            = cur_row[s];
            exp_valid[s] = 1'b1;
            exp_ar[s]    = 1'b0;
            exp_addr[s]  = row_addr[r];
            exp_len[s]   = row_len[r];
            exp_id[s]    = row_id[r];
            exp_mst[s]   = row_mst[r];
            exp_beat[s]  = 0;
         end
      end
   endtask

   task automatic watch_master_ar();
      id_out_u got_id;
      id_out_u want_id;
      int      s;
      for (int m = 0; m < n_master_port; m++) begin
         if (master_arvalid_o[m] && master_arready_i[m]) begin
            got_id.raw = master_arid_o[m];
            s          = -1;
            // pending burst for this master that carries the same id
            for (int t = 0; t < n_slave_port; t++) begin
               if (exp_valid[t] && !exp_ar[t] && exp_mst[t] == m &&
                   exp_id[t] == got_id.f.id) begin
                  s = t;
               end
            end
            if (s < 0) begin
               abort_run($sformatf("master port %0d got a request not meant for it", m));
            end
            want_id.f.src = log_n_slave'(s);   // issuing port on top
            want_id.f.id  = exp_id[s];
            check_addr("master_araddr_o", master_araddr_o[m], exp_addr[s]);
            check_len("master_arlen_o", master_arlen_o[m], exp_len[s]);
            check_id("master_arid_o", got_id, want_id);
            exp_ar[s]      = 1'b1;
            mem_pend[m][s] = 1'b1;
            mem_addr[m][s] = master_araddr_o[m];
            mem_len[m][s]  = master_arlen_o[m];
            mem_id[m][s]   = master_arid_o[m];   // returned unchanged
         end
      end
   endtask

   task automatic watch_slave_r();
      id_out_u           got_id;
      id_out_u           want_id;
      logic [data_w-1:0] want_data;
      logic [resp_w-1:0] want_resp;
      for (int s = 0; s < n_slave_port; s++) begin
         if (slave_rvalid_o[s] && slave_rready_i[s]) begin
            if (!exp_valid[s] || (exp_mst[s] != exp_decerr && !exp_ar[s])) begin
               abort_run($sformatf("read data on slave port %0d with no burst routed", s));
            end
            got_id.f.src  = log_n_slave'(s);
            got_id.f.id   = slave_rid_o[s];
            want_id.f.src = log_n_slave'(s);
            want_id.f.id  = exp_id[s];
            if (exp_mst[s] == exp_decerr) begin
               want_data = '0;
               want_resp = resp_decerr;
            end else begin
               want_data = mem_word(exp_mst[s], exp_addr[s], exp_beat[s]);
               want_resp = resp_okay;
            end
            check_id("slave_rid_o", got_id, want_id);
            check_data("slave_rdata_o", slave_rdata_o[s], want_data);
            check_resp("slave_rresp_o", slave_rresp_o[s], want_resp);
            check_bit("slave_rlast_o", slave_rlast_o[s], exp_beat[s] == int'(exp_len[s]));
            if (slave_rlast_o[s]) begin
               exp_valid[s] = 1'b0;
               bursts_done++;
            end else begin
               exp_beat[s]++;
            end
         end
      end
   endtask

   task automatic watch_master_r();
      for (int m = 0; m < n_master_port; m++) begin
         if (master_rvalid_i[m] && master_rready_o[m]) begin
            if (master_rlast_i[m]) begin
               mem_busy[m]              = 1'b0;
               mem_pend[m][mem_cur[m]]  = 1'b0;
            end else begin
               mem_beat[m]++;
            end
         end
      end
   endtask

   // memories answer one burst at a time with random readies
   task automatic drive_memories();
      int c;
      for (int m = 0; m < n_master_port; m++) begin
         for (int s = n_slave_port - 1; s >= 0; s--) begin
            if (!mem_busy[m] && mem_pend[m][s] && (s == 0 || !mem_pend[m][0])) begin
               mem_busy[m] = 1'b1;
               mem_cur[m]  = s;
               mem_beat[m] = 0;
            end
         end
         c                   = mem_cur[m];
         master_arready_i[m] = ($random(seed) & 3) != 0;
         master_rvalid_i[m]  = mem_busy[m];
         master_rid_i[m]     = mem_busy[m] ? mem_id[m][c] : '0;
         master_rdata_i[m]   = mem_busy[m] ? mem_word(m, mem_addr[m][c], mem_beat[m]) : '0;
         master_rresp_i[m]   = resp_okay;
         master_rlast_i[m]   = mem_busy[m] && (mem_beat[m] == int'(mem_len[m][c]));
      end
      for (int s = 0; s < n_slave_port; s++) begin
         slave_rready_i[s] = ($random(seed) & 3) != 0;
      end
   endtask

   always begin
      @(negedge clk);
      if (rst_n_i) begin
         watch_slave_ar();
         watch_master_ar();
         watch_slave_r();
         watch_master_r();
      end
      @(posedge clk);
      #2;
      drive_memories();
   end

   // rows of one slave port back to back with each waiting on arready
   task automatic issue_rows(input int s);
      for (int r = 0; r < n_rows; r++) begin
         if (row_slave[r] == s) begin
            cur_row[s]         = r;
            slave_arvalid_i[s] = 1'b1;
            slave_araddr_i[s]  = row_addr[r];
            slave_arlen_i[s]   = row_len[r];
            slave_arid_i[s]    = row_id[r];
            do begin
               @(negedge clk);
            end while (!slave_arready_o[s]);
            @(posedge clk);
            #2;
         end
      end
      slave_arvalid_i[s] = 1'b0;
   endtask

   initial begin
      wait (n_rows > 0);
      #(n_rows * 17 * 20 * 40);   // worst case beats and stalls per row
      $display("error %0t watchdog ran out before all bursts completed", $time);
      stop_run();
   end

   initial begin
      clk              = 1'b0;
      rst_n_i          = 1'b0;
      slave_arvalid_i  = '0;
      slave_araddr_i   = '0;
      slave_arlen_i    = '0;
      slave_arid_i     = '0;
      slave_rready_i   = '0;
      master_arready_i = '0;
      master_rvalid_i  = '0;
      master_rid_i     = '0;
      master_rdata_i   = '0;
      master_rresp_i   = '0;
      master_rlast_i   = '0;
      // --------------------
      // memory map
      cfg_start_addr_i       = '0;
      cfg_end_addr_i         = '0;
      cfg_valid_rule_i       = '0;
      cfg_start_addr_i[0][0] = 32'h0000_0000;
      cfg_end_addr_i[0][0]   = 32'h0fff_ffff;
      cfg_start_addr_i[0][1] = 32'h1000_0000;
      cfg_end_addr_i[0][1]   = 32'h1fff_ffff;
      cfg_start_addr_i[1][1] = 32'h4000_0000;
      cfg_end_addr_i[1][1]   = 32'h4fff_ffff;
      cfg_start_addr_i[0][2] = 32'h2000_0000;
      cfg_end_addr_i[0][2]   = 32'h2fff_ffff;
      cfg_start_addr_i[1][0] = 32'h3000_0000;   // disabled rules over 0x3xxx_xxxx
      cfg_end_addr_i[1][0]   = 32'h3fff_ffff;
      cfg_start_addr_i[1][2] = 32'h3000_0000;
      cfg_end_addr_i[1][2]   = 32'h3fff_ffff;
      cfg_valid_rule_i[0]    = '1;
      cfg_valid_rule_i[1][1] = 1'b1;
      cfg_connectivity_map_i[0] = '1;
      cfg_connectivity_map_i[1] = 3'b011;       // no path to master 2
      for (int s = 0; s < n_slave_port; s++) begin
         exp_valid[s] = 1'b0;
         cur_row[s]   = 0;
      end
      for (int m = 0; m < n_master_port; m++) begin
         mem_busy[m] = 1'b0;
         mem_cur[m]  = 0;
         mem_beat[m] = 0;
         for (int s = 0; s < n_slave_port; s++) begin
            mem_pend[m][s] = 1'b0;
         end
      end
      bursts_done = 0;
      n_rows      = 0;
      load_table();

      repeat (2) @(posedge clk);
      #2;
      rst_n_i = 1'b1;
      @(negedge clk);
      for (int s = 0; s < n_slave_port; s++) begin
         check_bit("slave_rvalid_o", slave_rvalid_o[s], 1'b0);
      end
      for (int m = 0; m < n_master_port; m++) begin
         check_bit("master_arvalid_o", master_arvalid_o[m], 1'b0);
      end
      @(posedge clk);
      #2;

      fork
         issue_rows(0);
         issue_rows(1);
      join
      wait (bursts_done == n_rows);
      repeat (4) @(posedge clk);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: logic/axi_node.sv
`timescale 1ns/10ps

module axi_node (
   input  logic                                                    clk,
   input  logic                                                    rst_n_i,
   // --------------------
   // slave ports
   input  logic [axi_node_pkg::n_slave_port-1:0]                   slave_arvalid_i,
   output logic [axi_node_pkg::n_slave_port-1:0]                   slave_arready_o,
   input  logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::addr_w-1:0]  slave_araddr_i,
   input  logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::len_w-1:0]   slave_arlen_i,
   input  logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::id_in_w-1:0] slave_arid_i,
   output logic [axi_node_pkg::n_slave_port-1:0]                   slave_rvalid_o,
   input  logic [axi_node_pkg::n_slave_port-1:0]                   slave_rready_i,
   output logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::id_in_w-1:0] slave_rid_o,
   output logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::data_w-1:0]  slave_rdata_o,
   output logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::resp_w-1:0]  slave_rresp_o,
   output logic [axi_node_pkg::n_slave_port-1:0]                   slave_rlast_o,
   // --------------------
   // master ports
   output logic [axi_node_pkg::n_master_port-1:0]                  master_arvalid_o,
   input  logic [axi_node_pkg::n_master_port-1:0]                  master_arready_i,
   output logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::addr_w-1:0] master_araddr_o,
   output logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::len_w-1:0]  master_arlen_o,
   output logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::id_out_w-1:0]
                                                                   master_arid_o,
   input  logic [axi_node_pkg::n_master_port-1:0]                  master_rvalid_i,
   output logic [axi_node_pkg::n_master_port-1:0]                  master_rready_o,
   input  logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::id_out_w-1:0]
                                                                   master_rid_i,
   input  logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::data_w-1:0] master_rdata_i,
   input  logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::resp_w-1:0] master_rresp_i,
   input  logic [axi_node_pkg::n_master_port-1:0]                  master_rlast_i,
   // --------------------
   // static memory map
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                [axi_node_pkg::addr_w-1:0]                         cfg_start_addr_i,
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                [axi_node_pkg::addr_w-1:0]                         cfg_end_addr_i,
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                                                                   cfg_valid_rule_i,
   input  logic [axi_node_pkg::n_slave_port-1:0][axi_node_pkg::n_master_port-1:0]
                                                                   cfg_connectivity_map_i
);
   import axi_node_pkg::*;

   axi_ar_if ar_bus [n_slave_port][n_master_port] ();   // [slave][master] request matrix
   axi_r_if  err_bus [n_slave_port] ();                 // decerr beats per slave port

   logic [n_slave_port-1:0][n_master_port-1:0] rready_mat;   // per router ready bits
   logic [n_slave_port-1:0]                    burst_done;

   for (genvar s = 0; s < n_slave_port; s++) begin : g_slave
      axi_ar_decoder #(.port_idx(s)) i_decoder (
         .clk                    (clk),
         .rst_n_i                (rst_n_i),
         .arvalid_i              (slave_arvalid_i[s]),
         .arready_o              (slave_arready_o[s]),
         .araddr_i               (slave_araddr_i[s]),
         .arlen_i                (slave_arlen_i[s]),
         .arid_i                 (slave_arid_i[s]),
         .cfg_start_addr_i       (cfg_start_addr_i),
         .cfg_end_addr_i         (cfg_end_addr_i),
         .cfg_valid_rule_i       (cfg_valid_rule_i),
         .cfg_connectivity_map_i (cfg_connectivity_map_i[s]),
         .burst_done_i           (burst_done[s]),
         .ar_o                   (ar_bus),
         .err_r_o                (err_bus[s])
      );

      axi_r_router #(.port_idx(s)) i_router (
         .master_rvalid_i (master_rvalid_i),
         .master_rready_o (rready_mat[s]),
         .master_rid_i    (master_rid_i),
         .master_rdata_i  (master_rdata_i),
         .master_rresp_i  (master_rresp_i),
         .master_rlast_i  (master_rlast_i),
         .err_r_i         (err_bus[s]),
         .slave_rvalid_o  (slave_rvalid_o[s]),
         .slave_rready_i  (slave_rready_i[s]),
         .slave_rid_o     (slave_rid_o[s]),
         .slave_rdata_o   (slave_rdata_o[s]),
         .slave_rresp_o   (slave_rresp_o[s]),
         .slave_rlast_o   (slave_rlast_o[s]),
         .burst_done_o    (burst_done[s])
      );
   end

   for (genvar m = 0; m < n_master_port; m++) begin : g_master
      axi_ar_arbiter #(.port_idx(m)) i_arbiter (
         .clk              (clk),
         .rst_n_i          (rst_n_i),
         .ar_i             (ar_bus),
         .master_arvalid_o (master_arvalid_o[m]),
         .master_arready_i (master_arready_i[m]),
         .master_araddr_o  (master_araddr_o[m]),
         .master_arlen_o   (master_arlen_o[m]),
         .master_arid_o    (master_arid_o[m])
      );
   end

   // only the owning router sets a bit, so OR them together
   always_comb begin
      master_rready_o = '0;
      for (int s = 0; s < n_slave_port; s++) begin
         master_rready_o = master_rready_o | rready_mat[s];
      end
   end

endmodule

// File: logic/axi_r_router.sv
`timescale 1ns/10ps

module axi_r_router #(
   parameter int port_idx = 0   // slave port served
) (
   input  logic [axi_node_pkg::n_master_port-1:0]                         master_rvalid_i,
   output logic [axi_node_pkg::n_master_port-1:0]                         master_rready_o,
   input  axi_node_pkg::id_out_u [axi_node_pkg::n_master_port-1:0]        master_rid_i,
   input  logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::data_w-1:0] master_rdata_i,
   input  logic [axi_node_pkg::n_master_port-1:0][axi_node_pkg::resp_w-1:0] master_rresp_i,
   input  logic [axi_node_pkg::n_master_port-1:0]                         master_rlast_i,
   axi_r_if.dst                                                           err_r_i,
   output logic                                                           slave_rvalid_o,
   input  logic                                                           slave_rready_i,
   output logic [axi_node_pkg::id_in_w-1:0]                               slave_rid_o,
   output logic [axi_node_pkg::data_w-1:0]                                slave_rdata_o,
   output logic [axi_node_pkg::resp_w-1:0]                                slave_rresp_o,
   output logic                                                           slave_rlast_o,
   output logic                                                           burst_done_o
);
   import axi_node_pkg::*;

   logic [n_master_port-1:0] hit;    // master ports returning data for us
   logic [log_n_master-1:0]  sel;
   logic                     any_m;

   always_comb begin
      hit = '0;
      for (int m = 0; m < n_master_port; m++) begin
         hit[m] = master_rvalid_i[m] && (master_rid_i[m].f.src == log_n_slave'(port_idx));
      end
   end

   always_comb begin
      sel = '0;
      for (int m = n_master_port - 1; m >= 0; m--) begin
         if (hit[m]) begin
            sel = log_n_master'(m);
         end
      end
   end

   assign any_m = |hit;

   // --------------------
   // data mux, error channel when no master is returning
   always_comb begin
      master_rready_o = '0;
      if (any_m) begin
         slave_rvalid_o       = 1'b1;
         slave_rid_o          = master_rid_i[sel].f.id;   // src field stripped
         slave_rdata_o        = master_rdata_i[sel];
         slave_rresp_o        = master_rresp_i[sel];
         slave_rlast_o        = master_rlast_i[sel];
         master_rready_o[sel] = slave_rready_i;
      end else begin
         slave_rvalid_o = err_r_i.valid;
         slave_rid_o    = err_r_i.id;
         slave_rdata_o  = err_r_i.data;
         slave_rresp_o  = err_r_i.resp;
         slave_rlast_o  = err_r_i.last;
      end
   end

   assign err_r_i.ready = ~any_m & slave_rready_i;
   assign burst_done_o  = slave_rvalid_o & slave_rready_i & slave_rlast_o;   // frees decoder

endmodule

// File: logic/axi_ar_arbiter.sv
`timescale 1ns/10ps

module axi_ar_arbiter #(
   parameter int port_idx = 0   // master port served
) (
   input  logic                               clk,
   input  logic                               rst_n_i,
   axi_ar_if.dst ar_i [axi_node_pkg::n_slave_port][axi_node_pkg::n_master_port],
   output logic                               master_arvalid_o,
   input  logic                               master_arready_i,
   output logic [axi_node_pkg::addr_w-1:0]    master_araddr_o,
   output logic [axi_node_pkg::len_w-1:0]     master_arlen_o,
   output axi_node_pkg::id_out_u              master_arid_o
);
   import axi_node_pkg::*;

   logic [n_slave_port-1:0]              req;       // column port_idx of the matrix
   logic [n_slave_port-1:0][addr_w-1:0]  addr_v;
   logic [n_slave_port-1:0][len_w-1:0]   len_v;
   logic [n_slave_port-1:0][id_in_w-1:0] id_v;
   logic [log_n_slave-1:0]               gnt;
   logic                                 gnt_any;
   logic [log_n_slave-1:0]               gnt_q;     // grant held while stalled
   logic                                 lock_q;
   logic [log_n_slave-1:0]               ptr_q;     // highest priority slave

   for (genvar s = 0; s < n_slave_port; s++) begin : g_req
      assign req[s]    = ar_i[s][port_idx].valid;
      assign addr_v[s] = ar_i[s][port_idx].addr;
      assign len_v[s]  = ar_i[s][port_idx].len;
      assign id_v[s]   = ar_i[s][port_idx].id;
      assign ar_i[s][port_idx].ready = master_arready_i & gnt_any &
                                       (gnt == log_n_slave'(s));
   end

   // --------------------
   // round robin from ptr_q
   always_comb begin
      int idx;
      gnt_any = 1'b0;
      gnt     = ptr_q;
      for (int k = 0; k < n_slave_port; k++) begin
         idx = (int'(ptr_q) + k) % n_slave_port;
         if (!gnt_any && req[idx]) begin
            gnt_any = 1'b1;
            gnt     = log_n_slave'(idx);
         end
      end
      if (lock_q) begin   // keep valid and payload stable
         gnt_any = 1'b1;
         gnt     = gnt_q;
      end
   end

   assign master_arvalid_o = gnt_any;
   assign master_araddr_o  = addr_v[gnt];
   assign master_arlen_o   = len_v[gnt];

   always_comb begin
      master_arid_o.f.src = gnt;   // prepend slave index
      master_arid_o.f.id  = id_v[gnt];
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lock_q <= 1'b0;
         gnt_q  <= '0;
         ptr_q  <= '0;
      end else begin
         lock_q <= master_arvalid_o & ~master_arready_i;
         gnt_q  <= gnt;
         if (master_arvalid_o && master_arready_i) begin
            // step past the winner
            ptr_q <= (gnt == log_n_slave'(n_slave_port - 1)) ? '0 : gnt + 1'b1;
         end
      end
   end

endmodule

// File: logic/axi_ar_decoder.sv
`timescale 1ns/10ps

module axi_ar_decoder #(
   parameter int port_idx = 0   // slave port served
) (
   input  logic                                       clk,
   input  logic                                       rst_n_i,
   input  logic                                       arvalid_i,
   output logic                                       arready_o,
   input  logic [axi_node_pkg::addr_w-1:0]            araddr_i,
   input  logic [axi_node_pkg::len_w-1:0]             arlen_i,
   input  logic [axi_node_pkg::id_in_w-1:0]           arid_i,
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                [axi_node_pkg::addr_w-1:0]            cfg_start_addr_i,
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                [axi_node_pkg::addr_w-1:0]            cfg_end_addr_i,
   input  logic [axi_node_pkg::n_region-1:0][axi_node_pkg::n_master_port-1:0]
                                                      cfg_valid_rule_i,
   input  logic [axi_node_pkg::n_master_port-1:0]     cfg_connectivity_map_i,
   input  logic                                       burst_done_i,   // from router
   axi_ar_if.src ar_o [axi_node_pkg::n_slave_port][axi_node_pkg::n_master_port],
   axi_r_if.src                                       err_r_o
);
   import axi_node_pkg::*;

   logic                     ar_hs;      // request taken this edge
   logic                     busy_d;
   logic [n_master_port-1:0] hit;        // allowed ports for araddr_i
   logic [log_n_master-1:0]  sel;
   logic [n_master_port-1:0] ar_ready;
   logic                     err_last;

   logic                     rdy_q;      // low in reset and while busy
   logic                     busy_q;     // burst outstanding
   logic                     req_q;      // ar valid pending on selected pair
   logic                     err_q;      // decerr beats going out
   logic [log_n_master-1:0]  sel_q;
   logic [len_w-1:0]         cnt_q;      // decerr beat index
   logic [addr_w-1:0]        addr_q;
   logic [len_w-1:0]         len_q;
   logic [id_in_w-1:0]       id_q;

   assign arready_o = rdy_q;
   assign ar_hs     = arvalid_i & rdy_q;
   assign busy_d    = ar_hs | (busy_q & ~burst_done_i);

   // --------------------
   // address decode
   always_comb begin
      hit = '0;
      for (int m = 0; m < n_master_port; m++) begin
         for (int r = 0; r < n_region; r++) begin
            if (cfg_valid_rule_i[r][m] && araddr_i >= cfg_start_addr_i[r][m] &&
                araddr_i <= cfg_end_addr_i[r][m]) begin
               hit[m] = cfg_connectivity_map_i[m];   // masked by connectivity
            end
         end
      end
   end

   always_comb begin
      sel = '0;
      for (int m = n_master_port - 1; m >= 0; m--) begin
         if (hit[m]) begin
            sel = log_n_master'(m);   // lowest index wins
         end
      end
   end

   // only our row of the matrix is driven here
   for (genvar m = 0; m < n_master_port; m++) begin : g_ar
      assign ar_o[port_idx][m].valid = req_q && (sel_q == log_n_master'(m));
      assign ar_o[port_idx][m].addr  = addr_q;
      assign ar_o[port_idx][m].len   = len_q;
      assign ar_o[port_idx][m].id    = id_q;
      assign ar_ready[m]             = ar_o[port_idx][m].ready;
   end

   // --------------------
   // decerr responder
   assign err_last      = (cnt_q == len_q);
   assign err_r_o.valid = err_q;
   assign err_r_o.data  = '0;
   assign err_r_o.resp  = resp_decerr;
   assign err_r_o.last  = err_last;
   assign err_r_o.id    = id_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdy_q  <= 1'b0;
         busy_q <= 1'b0;
         req_q  <= 1'b0;
         err_q  <= 1'b0;
         sel_q  <= '0;
         cnt_q  <= '0;
      end else begin
         busy_q <= busy_d;
         rdy_q  <= ~busy_d;   // rises one cycle after reset or burst end
         if (ar_hs) begin
            sel_q <= sel;
            req_q <= |hit;
            err_q <= ~|hit;   // nothing allowed, answer ourselves
            cnt_q <= '0;
         end else begin
            if (req_q && ar_ready[sel_q]) begin
               req_q <= 1'b0;
            end
            if (err_q && err_r_o.ready) begin
               if (err_last) begin
                  err_q <= 1'b0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         addr_q <= araddr_i;
         len_q  <= arlen_i;
         id_q   <= arid_i;
      end
   end

endmodule

// File: logic/axi_r_if.sv
`timescale 1ns/10ps

// read data from the decerr responder into the router
interface axi_r_if;
   import axi_node_pkg::*;

   logic               valid;
   logic               ready;
   logic [data_w-1:0]  data;
   logic [resp_w-1:0]  resp;
   logic               last;
   logic [id_in_w-1:0] id;

   modport src (output valid, output data, output resp, output last, output id,
                input ready);
   modport dst (input valid, input data, input resp, input last, input id,
                output ready);

endinterface

// File: logic/axi_ar_if.sv
`timescale 1ns/10ps

// read address channel, one per slave/master pair
interface axi_ar_if;
   import axi_node_pkg::*;

   logic               valid;
   logic               ready;
   logic [addr_w-1:0]  addr;
   logic [len_w-1:0]   len;
   logic [id_in_w-1:0] id;    // not yet extended

   modport src (output valid, output addr, output len, output id, input ready);   // decoder
   modport dst (input valid, input addr, input len, input id, output ready);      // arbiter

endinterface

// File: logic/axi_node_pkg.sv
package axi_node_pkg;

   // --------------------
   // port counts
   localparam int n_slave_port  = 2;   // target side, bus masters attach here
   localparam int n_master_port = 3;   // initiator side, memories attach here
   localparam int n_region      = 2;   // address rules per master port

   localparam int log_n_slave  = (n_slave_port > 1) ? $clog2(n_slave_port) : 1;
   localparam int log_n_master = (n_master_port > 1) ? $clog2(n_master_port) : 1;

   // --------------------
   // channel widths
   localparam int addr_w   = 32;
   localparam int data_w   = 32;
   localparam int len_w    = 8;                      // beats minus one
   localparam int resp_w   = 2;
   localparam int id_in_w  = 4;
   localparam int id_out_w = id_in_w + log_n_slave;  // slave index on top

   localparam logic [resp_w-1:0] resp_okay   = 2'b00;
   localparam logic [resp_w-1:0] resp_decerr = 2'b11;

   // extended id as seen on the master ports
   typedef struct packed {
      logic [log_n_slave-1:0] src;   // issuing slave port
      logic [id_in_w-1:0]     id;    // id as it came in
   } id_out_s;

   typedef union packed {
      logic [id_out_w-1:0] raw;
      id_out_s             f;
   } id_out_u;

endpackage
